/* common/pipe_sync_cfg_pkg.sv */
package pipe_sync_cfg_pkg;

    // Flops per status chain, last one is the edge history
    localparam int sync_stages = 3;

    // One-hot state widths
    localparam int tx_state_w  = 6;
    localparam int rx_state_w  = 7;

    // Status bits carried through each synchronizer
    localparam int tx_status_w = 5;
    localparam int rx_status_w = 9;

endpackage

/* common/pipe_sync_state_pkg.sv */
package pipe_sync_state_pkg;

    import pipe_sync_cfg_pkg::*;

    typedef enum logic [tx_state_w-1:0] {
        tx_idle      = 6'b000001,
        tx_mmcm_lock = 6'b000010,
        tx_start     = 6'b000100,   // TX delay reset
        tx_phinit    = 6'b001000,
        tx_done1     = 6'b010000,   // TX phase align
        tx_done2     = 6'b100000
    } tx_state_t;

    typedef enum logic [rx_state_w-1:0] {
        rx_idle    = 7'b0000001,
        rx_cdrlock = 7'b0000010,
        rx_start   = 7'b0000100,    // RX delay reset
        rx_done1   = 7'b0001000,    // RX phase align
        rx_done2   = 7'b0010000,
        rx_dones   = 7'b0100000,    // Master waits on slaves
        rx_donem   = 7'b1000000
    } rx_state_t;

    typedef struct packed {
        logic txsync_start;
        logic mmcm_lock;
        logic txdlysresetdone;
        logic txphinitdone;
        logic txphaligndone;
    } tx_status_t;

    typedef struct packed {
        logic rxsync_start;
        logic gen3;
        logic rate_idle;
        logic rxelecidle;
        logic rxcdrlock;
        logic rxdlysresetdone;
        logic rxphaligndone_m;
        logic rxphaligndone_s;
        logic rxsync_donem_in;
    } rx_status_t;

endpackage

/* rtl/pipe_status_sync.sv */
module pipe_status_sync
    import pipe_sync_cfg_pkg::*;
#(
    parameter type payload_t = logic
)
(
    input  logic     sync_clk,
    input  logic     sync_rst_n,
    input  payload_t status,
    output payload_t level,
    output payload_t rise,
    output payload_t fall
);

    payload_t stage_q [sync_stages];

    always_ff @(posedge sync_clk)
    begin
        if (!sync_rst_n)
        begin
            for (int i = 0; i < sync_stages; i++)
            begin
                stage_q[i] <= '0;
            end
        end
        else
        begin
            stage_q[0] <= status;   // Async capture
            for (int i = 1; i < sync_stages; i++)
            begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // Last stage only serves as edge history
    assign level = stage_q[sync_stages-2];
    assign rise  = payload_t'(stage_q[sync_stages-2] & ~stage_q[sync_stages-1]);
    assign fall  = payload_t'(~stage_q[sync_stages-2] & stage_q[sync_stages-1]);

    a_rise_fall_excl: assert property (
        @(posedge sync_clk) disable iff (!sync_rst_n)
        (rise & fall) == '0
    );

endmodule

/* txsync/txsync_fsm.sv */
module txsync_fsm
    import pipe_sync_state_pkg::*;
(
    input  logic       sync_clk,
    input  logic       sync_rst_n,
    input  logic       sync_slave,
    input  logic       sync_active_lane,
    input  tx_status_t level,
    input  tx_status_t rise,
    input  tx_status_t fall,
    output logic       txdlysreset,
    output logic       txphinit,
    output logic       txphalign,
    output logic       txdlyen,
    output logic       txsync_done,
    output tx_state_t  fsm_tx
);

    always_ff @(posedge sync_clk)
    begin
        if (!sync_rst_n)
        begin
            fsm_tx      <= tx_idle;
            txdlyen     <= 1'b0;
            txsync_done <= 1'b0;
        end
        else
        begin
            case (fsm_tx)
                tx_idle:
                begin
                    if (level.txsync_start)
                    begin
                        fsm_tx      <= tx_mmcm_lock;
                        txdlyen     <= 1'b0;
                        txsync_done <= 1'b0;
                    end
                end
                tx_mmcm_lock:
                begin
                    if (level.mmcm_lock)
                        fsm_tx <= tx_start;
                end
                tx_start:
                begin
                    if (rise.txdlysresetdone)
                        fsm_tx <= tx_phinit;
                end
                tx_phinit:
                begin
                    if (rise.txphinitdone || !sync_active_lane)
                        fsm_tx <= tx_done1;
                end
                tx_done1:
                begin
                    if (rise.txphaligndone || !sync_active_lane)
                        fsm_tx <= tx_done2;
                end
                tx_done2:
                begin
                    txdlyen <= !sync_slave;     // Slaves never enable delay align
                    if (rise.txphaligndone || !sync_active_lane || sync_slave)
                    begin
                        fsm_tx      <= tx_idle;
                        txsync_done <= 1'b1;
                    end
                end
                default:
                begin
                    fsm_tx      <= tx_idle;
                    txdlyen     <= 1'b0;
                    txsync_done <= 1'b0;
                end
            endcase
        end
    end

    assign txdlysreset = (fsm_tx == tx_start);
    assign txphinit    = (fsm_tx == tx_phinit);
    assign txphalign   = (fsm_tx == tx_done1);

    a_tx_onehot: assert property (
        @(posedge sync_clk) disable iff (!sync_rst_n)
        $onehot(fsm_tx)
    );

    a_tx_done_idle: assert property (
        @(posedge sync_clk) disable iff (!sync_rst_n)
        txsync_done |-> (fsm_tx == tx_idle)
    );

endmodule

/* rxsync/rxsync_fsm.sv */
module rxsync_fsm
    import pipe_sync_state_pkg::*;
(
    input  logic       sync_clk,
    input  logic       sync_rst_n,
    input  logic       sync_slave,
    input  rx_status_t level,
    input  rx_status_t rise,
    input  rx_status_t fall,
    output logic       rxdlysreset,
    output logic       rxphalign,
    output logic       rxphalignen,
    output logic       rxdlybypass,
    output logic       rxddien,
    output logic       rxdlyen,
    output logic       rxsync_done,
    output logic       rxsync_donem_out,
    output rx_state_t  fsm_rx
);

    logic own_phaligndone;      // Phase-align done of this lane's role
    logic eios_exit;            // Electrical idle exit at gen3 rate idle

    assign own_phaligndone = sync_slave ? rise.rxphaligndone_s : rise.rxphaligndone_m;
    assign eios_exit       = level.gen3 && level.rate_idle && fall.rxelecidle;

    always_ff @(posedge sync_clk)
    begin
        if (!sync_rst_n)
        begin
            fsm_rx      <= rx_idle;
            rxdlyen     <= 1'b0;
            rxsync_done <= 1'b0;
        end
        else
        begin
            case (fsm_rx)
                rx_idle:
                begin
                    if (level.rxsync_start || eios_exit)
                    begin
                        fsm_rx      <= rx_cdrlock;
                        rxdlyen     <= 1'b0;
                        rxsync_done <= 1'b0;
                    end
                    else if (level.rxelecidle)
                    begin
                        rxdlyen     <= 1'b0;     // Link went idle
                        rxsync_done <= 1'b0;
                    end
                end
                rx_cdrlock:
                begin
                    if (level.rxcdrlock && !level.rxelecidle)
                        fsm_rx <= rx_start;
                end
                rx_start:
                begin
                    if (rise.rxdlysresetdone)
                        fsm_rx <= rx_done1;
                end
                rx_done1:
                begin
                    if (own_phaligndone)
                        fsm_rx <= rx_done2;
                end
                rx_done2:
                begin
                    if (sync_slave)
                    begin
                        fsm_rx      <= rx_idle;
                        rxdlyen     <= 1'b0;
                        rxsync_done <= 1'b1;
                    end
                    else if (rise.rxphaligndone_m)
                    begin
                        fsm_rx  <= rx_dones;
                        rxdlyen <= 1'b0;
                    end
                    else
                    begin
                        rxdlyen <= 1'b1;
                    end
                end
                rx_dones:
                begin
                    if (rise.rxphaligndone_s)
                    begin
                        fsm_rx  <= rx_donem;
                        rxdlyen <= 1'b1;
                    end
                    else
                    begin
                        rxdlyen <= 1'b0;
                    end
                end
                rx_donem:
                begin
                    rxdlyen <= 1'b1;
                    if (rise.rxphaligndone_m)
                    begin
                        fsm_rx      <= rx_idle;
                        rxsync_done <= 1'b1;
                    end
                end
                default:
                begin
                    fsm_rx      <= rx_idle;
                    rxdlyen     <= 1'b0;
                    rxsync_done <= 1'b0;
                end
            endcase
        end
    end

    assign rxdlysreset      = (fsm_rx == rx_start);
    assign rxphalign        = (fsm_rx == rx_done1) && (!sync_slave || level.rxsync_donem_in);
    assign rxsync_donem_out = (fsm_rx == rx_dones);

    // Buffer bypass only at gen3
    assign rxphalignen = level.gen3;
    assign rxddien     = level.gen3;
    assign rxdlybypass = !level.gen3;

    a_rx_onehot: assert property (
        @(posedge sync_clk) disable iff (!sync_rst_n)
        $onehot(fsm_rx)
    );

    a_rx_slave_order: assert property (
        @(posedge sync_clk) disable iff (!sync_rst_n)
        sync_slave |-> !(fsm_rx inside {rx_dones, rx_donem})
    );

endmodule

/* rtl/pipe_sync.sv */
module pipe_sync
    import pipe_sync_state_pkg::*;
(
    input  logic      sync_clk,
    input  logic      sync_rst_n,
    input  logic      sync_slave,
    input  logic      sync_active_lane,
    input  logic      sync_txsync_start,
    input  logic      sync_mmcm_lock,
    input  logic      sync_txdlysresetdone,
    input  logic      sync_txphinitdone,
    input  logic      sync_txphaligndone,
    input  logic      sync_rxsync_start,
    input  logic      sync_gen3,
    input  logic      sync_rate_idle,
    input  logic      sync_rxelecidle,
    input  logic      sync_rxcdrlock,
    input  logic      sync_rxdlysresetdone,
    input  logic      sync_rxphaligndone_m,
    input  logic      sync_rxphaligndone_s,
    input  logic      sync_rxsync_donem_in,
    output logic      sync_txdlysreset,
    output logic      sync_txphinit,
    output logic      sync_txphalign,
    output logic      sync_txdlyen,
    output logic      sync_txsync_done,
    output tx_state_t sync_fsm_tx,
    output logic      sync_rxdlysreset,
    output logic      sync_rxphalign,
    output logic      sync_rxphalignen,
    output logic      sync_rxdlybypass,
    output logic      sync_rxddien,
    output logic      sync_rxdlyen,
    output logic      sync_rxsync_done,
    output logic      sync_rxsync_donem_out,
    output rx_state_t sync_fsm_rx
);

    tx_status_t tx_status;
    tx_status_t tx_level;
    tx_status_t tx_rise;
    tx_status_t tx_fall;
    rx_status_t rx_status;
    rx_status_t rx_level;
    rx_status_t rx_rise;
    rx_status_t rx_fall;

    assign tx_status.txsync_start    = sync_txsync_start;
    assign tx_status.mmcm_lock       = sync_mmcm_lock;
    assign tx_status.txdlysresetdone = sync_txdlysresetdone;
    assign tx_status.txphinitdone    = sync_txphinitdone;
    assign tx_status.txphaligndone   = sync_txphaligndone;

    assign rx_status.rxsync_start    = sync_rxsync_start;
    assign rx_status.gen3            = sync_gen3;
    assign rx_status.rate_idle       = sync_rate_idle;
    assign rx_status.rxelecidle      = sync_rxelecidle;
    assign rx_status.rxcdrlock       = sync_rxcdrlock;
    assign rx_status.rxdlysresetdone = sync_rxdlysresetdone;
    assign rx_status.rxphaligndone_m = sync_rxphaligndone_m;
    assign rx_status.rxphaligndone_s = sync_rxphaligndone_s;
    assign rx_status.rxsync_donem_in = sync_rxsync_donem_in;

    pipe_status_sync #(.payload_t(tx_status_t)) u_tx_status (
        .sync_clk   (sync_clk),
        .sync_rst_n (sync_rst_n),
        .status     (tx_status),
        .level      (tx_level),
        .rise       (tx_rise),
        .fall       (tx_fall)
    );

    pipe_status_sync #(.payload_t(rx_status_t)) u_rx_status (
        .sync_clk   (sync_clk),
        .sync_rst_n (sync_rst_n),
        .status     (rx_status),
        .level      (rx_level),
        .rise       (rx_rise),
        .fall       (rx_fall)
    );

    // Slave and active-lane are static config, no sync needed
    txsync_fsm u_txsync_fsm (
        .sync_clk         (sync_clk),
        .sync_rst_n       (sync_rst_n),
        .sync_slave       (sync_slave),
        .sync_active_lane (sync_active_lane),
        .level            (tx_level),
        .rise             (tx_rise),
        .fall             (tx_fall),
        .txdlysreset      (sync_txdlysreset),
        .txphinit         (sync_txphinit),
        .txphalign        (sync_txphalign),
        .txdlyen          (sync_txdlyen),
        .txsync_done      (sync_txsync_done),
        .fsm_tx           (sync_fsm_tx)
    );

    rxsync_fsm u_rxsync_fsm (
        .sync_clk         (sync_clk),
        .sync_rst_n       (sync_rst_n),
        .sync_slave       (sync_slave),
        .level            (rx_level),
        .rise             (rx_rise),
        .fall             (rx_fall),
        .rxdlysreset      (sync_rxdlysreset),
        .rxphalign        (sync_rxphalign),
        .rxphalignen      (sync_rxphalignen),
        .rxdlybypass      (sync_rxdlybypass),
        .rxddien          (sync_rxddien),
        .rxdlyen          (sync_rxdlyen),
        .rxsync_done      (sync_rxsync_done),
        .rxsync_donem_out (sync_rxsync_donem_out),
        .fsm_rx           (sync_fsm_rx)
    );

endmodule

/* dv/pipe_sync_tb.sv */
module pipe_sync_tb
    import pipe_sync_cfg_pkg::*;
    import pipe_sync_state_pkg::*;
();

    localparam int runs           = 4;
    localparam int reset_cycles   = 10;
    localparam int cycles_per_run = 4000;
    localparam int max_cycles     = runs * (cycles_per_run + reset_cycles + 1) + 200;

    logic       sync_clk;
    logic       sync_rst_n;
    logic       sync_slave;
    logic       sync_active_lane;
    logic [13:0] stim;          // RX status in [13:5], TX status in [4:0]
    integer     seed = 32'h404c;
    int         cycle_cnt = 0;

    logic       sync_txdlysreset, sync_txphinit, sync_txphalign;
    logic       sync_txdlyen, sync_txsync_done;
    tx_state_t  sync_fsm_tx;
    logic       sync_rxdlysreset, sync_rxphalign, sync_rxphalignen, sync_rxdlybypass;
    logic       sync_rxddien, sync_rxdlyen, sync_rxsync_done, sync_rxsync_donem_out;
    rx_state_t  sync_fsm_rx;

    // Reference model
    logic [13:0] s1, s2, s3;
    tx_status_t tl, tr;
    rx_status_t rl, rr, rf;
    tx_state_t  m_tx;
    rx_state_t  m_rx;
    logic       m_txdlyen, m_txdone, m_rxdlyen, m_rxdone;
    int         tx_seq_cnt = 0;
    int         rx_master_cnt = 0;
    int         rx_slave_cnt = 0;

    pipe_sync u_pipe_sync (
        .sync_clk              (sync_clk),
        .sync_rst_n            (sync_rst_n),
        .sync_slave            (sync_slave),
        .sync_active_lane      (sync_active_lane),
        .sync_txsync_start     (stim[4]),
        .sync_mmcm_lock        (stim[3]),
        .sync_txdlysresetdone  (stim[2]),
        .sync_txphinitdone     (stim[1]),
        .sync_txphaligndone    (stim[0]),
        .sync_rxsync_start     (stim[13]),
        .sync_gen3             (stim[12]),
        .sync_rate_idle        (stim[11]),
        .sync_rxelecidle       (stim[10]),
        .sync_rxcdrlock        (stim[9]),
        .sync_rxdlysresetdone  (stim[8]),
        .sync_rxphaligndone_m  (stim[7]),
        .sync_rxphaligndone_s  (stim[6]),
        .sync_rxsync_donem_in  (stim[5]),
        .sync_txdlysreset      (sync_txdlysreset),
        .sync_txphinit         (sync_txphinit),
        .sync_txphalign        (sync_txphalign),
        .sync_txdlyen          (sync_txdlyen),
        .sync_txsync_done      (sync_txsync_done),
        .sync_fsm_tx           (sync_fsm_tx),
        .sync_rxdlysreset      (sync_rxdlysreset),
        .sync_rxphalign        (sync_rxphalign),
        .sync_rxphalignen      (sync_rxphalignen),
        .sync_rxdlybypass      (sync_rxdlybypass),
        .sync_rxddien          (sync_rxddien),
        .sync_rxdlyen          (sync_rxdlyen),
        .sync_rxsync_done      (sync_rxsync_done),
        .sync_rxsync_donem_out (sync_rxsync_donem_out),
        .sync_fsm_rx           (sync_fsm_rx)
    );

    initial
    begin
        sync_clk = 1'b0;
        forever #5 sync_clk = ~sync_clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // Rare toggles so levels are held for many cycles
    always @(posedge sync_clk)
    begin
        for (int i = 0; i < 14; i++)
        begin
            if (($random(seed) & 15) == 0)
                stim[i] <= !stim[i];
        end
    end

    always @(posedge sync_clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles)
            fail_run("Timeout: random runs did not finish within the cycle limit");
    end

    assign tl = tx_status_t'(s2[4:0]);
    assign tr = tx_status_t'(s2[4:0] & ~s3[4:0]);
    assign rl = rx_status_t'(s2[13:5]);
    assign rr = rx_status_t'(s2[13:5] & ~s3[13:5]);
    assign rf = rx_status_t'(~s2[13:5] & s3[13:5]);

    always @(posedge sync_clk)
    begin
        if (!sync_rst_n)
        begin
            {s1, s2, s3} <= '0;
            m_tx         <= tx_idle;
            m_rx         <= rx_idle;
            {m_txdlyen, m_txdone, m_rxdlyen, m_rxdone} <= '0;
        end
        else
        begin
            s1 <= stim;
            s2 <= s1;
            s3 <= s2;

            if (m_tx == tx_idle && tl.txsync_start)
            begin
                m_tx      <= tx_mmcm_lock;
                m_txdlyen <= 1'b0;
                m_txdone  <= 1'b0;
            end
            else if (m_tx == tx_mmcm_lock && tl.mmcm_lock)
                m_tx <= tx_start;
            else if (m_tx == tx_start && tr.txdlysresetdone)
                m_tx <= tx_phinit;
            else if (m_tx == tx_phinit && (tr.txphinitdone || !sync_active_lane))
                m_tx <= tx_done1;
            else if (m_tx == tx_done1 && (tr.txphaligndone || !sync_active_lane))
                m_tx <= tx_done2;
            if (m_tx == tx_done2)
            begin
                m_txdlyen <= !sync_slave;
                if (tr.txphaligndone || !sync_active_lane || sync_slave)
                begin
                    m_tx     <= tx_idle;
                    m_txdone <= 1'b1;
                    if (!sync_slave && sync_active_lane)
                        tx_seq_cnt <= tx_seq_cnt + 1;   // Full master sequence
                end
            end

            if (m_rx == rx_idle)
            begin
                if (rl.rxsync_start || (rl.gen3 && rl.rate_idle && rf.rxelecidle))
                    m_rx <= rx_cdrlock;
                if (rl.rxsync_start || rl.gen3 && rl.rate_idle && rf.rxelecidle
                    || rl.rxelecidle)
                begin
                    m_rxdlyen <= 1'b0;
                    m_rxdone  <= 1'b0;
                end
            end
            else if (m_rx == rx_cdrlock && rl.rxcdrlock && !rl.rxelecidle)
                m_rx <= rx_start;
            else if (m_rx == rx_start && rr.rxdlysresetdone)
                m_rx <= rx_done1;
            else if (m_rx == rx_done1)
            begin
                if (sync_slave ? rr.rxphaligndone_s : rr.rxphaligndone_m)
                    m_rx <= rx_done2;
            end
            else if (m_rx == rx_done2 && sync_slave)
            begin
                m_rx         <= rx_idle;
                m_rxdlyen    <= 1'b0;
                m_rxdone     <= 1'b1;
                rx_slave_cnt <= rx_slave_cnt + 1;
            end
            else if (m_rx == rx_done2)
            begin
                m_rxdlyen <= !rr.rxphaligndone_m;
                if (rr.rxphaligndone_m)
                    m_rx <= rx_dones;
            end
            else if (m_rx == rx_dones)
            begin
                m_rxdlyen <= rr.rxphaligndone_s;    // Master waits for the slaves
                if (rr.rxphaligndone_s)
                    m_rx <= rx_donem;
            end
            else if (m_rx == rx_donem)
            begin
                m_rxdlyen <= 1'b1;
                if (rr.rxphaligndone_m)
                begin
                    m_rx          <= rx_idle;
                    m_rxdone      <= 1'b1;
                    rx_master_cnt <= rx_master_cnt + 1;
                end
            end
        end
    end

    always @(negedge sync_clk)
    begin
        if (cycle_cnt > 0)
        begin
            check_value("sync_fsm_tx", sync_fsm_tx, m_tx);
            check_value("sync_txdlysreset", sync_txdlysreset, m_tx == tx_start);
            check_value("sync_txphinit", sync_txphinit, m_tx == tx_phinit);
            check_value("sync_txphalign", sync_txphalign, m_tx == tx_done1);
            check_value("sync_txdlyen", sync_txdlyen, m_txdlyen);
            check_value("sync_txsync_done", sync_txsync_done, m_txdone);
            check_value("sync_fsm_rx", sync_fsm_rx, m_rx);
            check_value("sync_rxdlysreset", sync_rxdlysreset, m_rx == rx_start);
            check_value("sync_rxphalign", sync_rxphalign,
                        m_rx == rx_done1 && (!sync_slave || rl.rxsync_donem_in));
            check_value("sync_rxsync_donem_out", sync_rxsync_donem_out, m_rx == rx_dones);
            check_value("sync_rxphalignen", sync_rxphalignen, rl.gen3);
            check_value("sync_rxddien", sync_rxddien, rl.gen3);
            check_value("sync_rxdlybypass", sync_rxdlybypass, !rl.gen3);
            check_value("sync_rxdlyen", sync_rxdlyen, m_rxdlyen);
            check_value("sync_rxsync_done", sync_rxsync_done, m_rxdone);
        end
    end

    initial
    begin
        sync_rst_n       = 1'b0;
        sync_slave       = 1'b0;
        sync_active_lane = 1'b1;
        stim             = '0;
        for (int run = 0; run < runs; run++)
        begin
            @(posedge sync_clk);
            sync_rst_n       <= 1'b0;
            sync_slave       <= run[0];     // Master, slave, then both on an inactive lane
            sync_active_lane <= !run[1];
            repeat (reset_cycles) @(posedge sync_clk);
            sync_rst_n <= 1'b1;
            repeat (cycles_per_run) @(posedge sync_clk);
        end
        if (tx_seq_cnt > 0 && rx_master_cnt > 0 && rx_slave_cnt > 0)
        begin
            $display("TB PASSED");
            $finish;
        end
        else
        begin
            fail_run("Random stimulus did not complete every kind of sync sequence");
        end
    end

endmodule

/* pipe_sync.f */
common/pipe_sync_cfg_pkg.sv
common/pipe_sync_state_pkg.sv
rtl/pipe_status_sync.sv
txsync/txsync_fsm.sv
rxsync/rxsync_fsm.sv
rtl/pipe_sync.sv
dv/pipe_sync_tb.sv

/* Bender.yml */
package:
  name: pipe_sync

sources:
  - common/pipe_sync_cfg_pkg.sv
  - common/pipe_sync_state_pkg.sv
  - rtl/pipe_status_sync.sv
  - txsync/txsync_fsm.sv
  - rxsync/rxsync_fsm.sv
  - rtl/pipe_sync.sv
  - target: simulation
    files:
      - dv/pipe_sync_tb.sv
